// ==== files.f ====
verilog/lane_pkg.sv
verilog/eq_pkg.sv
verilog/stage_if.sv
verilog/code_history.sv
verilog/ffe_stage.sv
verilog/slicer_stage.sv
verilog/bit_aligner.sv
verilog/bits_estimator_top.sv
tb/tb_eq_model_pkg.sv
tb/tb_bits_estimator.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module tb_bits_estimator \
    -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$log_file"; then
    echo "Failures found in $log_file"
    exit 1
fi

echo "No failures found in $log_file"
exit 0

// ==== tb/tb_bits_estimator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bits_estimator;

    localparam int phases          = 4;
    localparam int blocks          = 8;
    localparam int words_per_block = 25;
    localparam int drain_cycles    = eq_pkg::latency + 2;
    localparam int reset_cycles    = 3;
    // Worst case where every word follows a bubble
    localparam int max_cycles = reset_cycles + 20
        + phases * (1 + blocks * (1 + 2 * words_per_block + drain_cycles));

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         in_valid;
    tb_eq_model_pkg::code_word_t   in_codes;
    tb_eq_model_pkg::weight_set_t  weights;
    tb_eq_model_pkg::disable_set_t disable_product;
    tb_eq_model_pkg::shift_set_t   ffe_shift;
    tb_eq_model_pkg::thresh_set_t  thresh;
    lane_pkg::align_t             align_pos;
    logic                         out_valid;
    tb_eq_model_pkg::code_word_t   out_codes;
    tb_eq_model_pkg::est_word_t    out_est;
    tb_eq_model_pkg::bit_word_t    out_bits;

    // Expected words in output order
    tb_eq_model_pkg::code_word_t exp_codes_q[$];
    tb_eq_model_pkg::est_word_t  exp_est_q[$];
    tb_eq_model_pkg::bit_word_t  exp_bits_q[$];
    tb_eq_model_pkg::code_word_t exp_codes = '0;
    tb_eq_model_pkg::est_word_t  exp_est = '0;
    tb_eq_model_pkg::bit_word_t  exp_bits = '0;

    // Model history moves on valid words only
    tb_eq_model_pkg::code_word_t model_prev_codes = '0;
    tb_eq_model_pkg::bit_word_t  model_prev_bits = '0;

    logic [31:0]                lfsr_state = 32'h54858968;
    logic [eq_pkg::latency-1:0] valid_dly = '0;
    logic                       rst_d = 1'b0;
    int                         cycles = 0;
    int                         words_sent = 0;
    int                         words_seen = 0;
    int                         valid_errors = 0;
    int                         data_errors = 0;
    int                         other_errors = 0;

    bits_estimator_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_codes        (in_codes),
        .weights         (weights),
        .disable_product (disable_product),
        .ffe_shift       (ffe_shift),
        .thresh          (thresh),
        .align_pos       (align_pos),
        .out_valid       (out_valid),
        .out_codes       (out_codes),
        .out_est         (out_est),
        .out_bits        (out_bits)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        if (s[0]) begin
            n = (s >> 1) ^ 32'h80200003;
        end else begin
            n = s >> 1;
        end
        return n;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic drive_bubble();
        logic [31:0]                 r;
        tb_eq_model_pkg::code_word_t junk;
        for (int i = 0; i < lane_pkg::lanes; i++) begin
            r = take_bits(lane_pkg::code_w);
            junk[i] = lane_pkg::code_t'(r[lane_pkg::code_w-1:0]);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        // Bubble codes must stay out of the history
        in_codes <= junk;
    endtask

    task automatic send_word();
        logic [31:0]                 r;
        tb_eq_model_pkg::code_word_t codes;
        tb_eq_model_pkg::est_word_t  est;
        tb_eq_model_pkg::bit_word_t  bits;
        r = take_bits(2);
        if (r[1:0] == 2'b00) begin
            drive_bubble();
        end
        @(posedge clk);
        for (int i = 0; i < lane_pkg::lanes; i++) begin
            r = take_bits(lane_pkg::code_w);
            codes[i] = lane_pkg::code_t'(r[lane_pkg::code_w-1:0]);
        end
        est = tb_eq_model_pkg::ffe_word(codes, model_prev_codes, weights, disable_product,
                                        ffe_shift);
        bits = tb_eq_model_pkg::slice_word(est, thresh);
        exp_codes_q.push_back(codes);
        exp_est_q.push_back(est);
        exp_bits_q.push_back(tb_eq_model_pkg::align_word(model_prev_bits, bits, align_pos));
        model_prev_codes = codes;
        model_prev_bits  = bits;
        in_valid <= 1'b1;
        in_codes <= codes;
        words_sent++;
    endtask

    // Only called with the pipeline drained
    task automatic configure(input int phase);
        logic [31:0]                  r;
        tb_eq_model_pkg::weight_set_t  w;
        tb_eq_model_pkg::disable_set_t d;
        tb_eq_model_pkg::shift_set_t   sh;
        tb_eq_model_pkg::thresh_set_t  th;
        for (int i = 0; i < lane_pkg::lanes; i++) begin
            for (int k = 0; k < eq_pkg::taps; k++) begin
                r = take_bits(9);
                w[k][i] = eq_pkg::weight_t'(r[7:0]);
                case (phase)
                    2:       d[k][i] = r[8];
                    3:       d[k][i] = 1'b1;
                    default: d[k][i] = 1'b0;
                endcase
            end
            r = take_bits(13);
            // Unshifted sums of full-range weights run into saturation
            if (phase == 1) begin
                sh[i] = eq_pkg::shift_t'(0);
            end else begin
                sh[i] = eq_pkg::shift_t'(r[2:0]);
            end
            th[i] = eq_pkg::thresh_t'($signed(r[12:3]) >>> 2);
        end
        @(posedge clk);
        weights         <= w;
        disable_product <= d;
        ffe_shift       <= sh;
        thresh          <= th;
    endtask

    task automatic set_align(input int pos);
        @(posedge clk);
        in_valid  <= 1'b0;
        align_pos <= lane_pkg::align_t'(pos);
    endtask

    always @(posedge clk) begin
        valid_dly <= {valid_dly[eq_pkg::latency-2:0], in_valid};
        rst_d     <= rst_n;
        cycles    <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Words sent %0d, checked %0d; errors valid %0d, data %0d, other %0d",
                     words_sent, words_seen, valid_errors, data_errors, other_errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Outputs have settled half a period after they change
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (exp_codes_q.size() == 0) begin
                other_errors++;
                $display("out_valid is high but no word is waiting to come out");
            end else begin
                exp_codes = exp_codes_q.pop_front();
                exp_est   = exp_est_q.pop_front();
                exp_bits  = exp_bits_q.pop_front();
                words_seen++;
            end
        end
    end

    a_reset_quiet: assert property (
        @(posedge clk) (cycles > 0 && (!rst_n || !rst_d)) |-> !out_valid)
        else begin
            valid_errors++;
            $display("ERROR: out_valid got %h expected 0 near reset", $sampled(out_valid));
        end

    a_valid_delay: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == valid_dly[eq_pkg::latency-1])
        else begin
            valid_errors++;
            $display("ERROR: out_valid got %h expected %h", $sampled(out_valid),
                     $sampled(valid_dly[eq_pkg::latency-1]));
        end

    a_codes: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> out_codes == exp_codes)
        else begin
            data_errors++;
            $display("ERROR: out_codes got %h expected %h", $sampled(out_codes),
                     $sampled(exp_codes));
        end

    a_est: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> out_est == exp_est)
        else begin
            data_errors++;
            $display("ERROR: out_est got %h expected %h", $sampled(out_est), $sampled(exp_est));
        end

    a_bits: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> out_bits == exp_bits)
        else begin
            data_errors++;
            $display("ERROR: out_bits got %h expected %h", $sampled(out_bits),
                     $sampled(exp_bits));
        end

    // No product left means no signal at all
    a_all_disabled: assert property (
        @(posedge clk) disable iff (!rst_n) (out_valid && (&disable_product)) |-> out_est == '0)
        else begin
            data_errors++;
            $display("ERROR: out_est got %h expected 0 with all products off",
                     $sampled(out_est));
        end

    initial begin
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        in_codes        = '0;
        weights         = '0;
        disable_product = '0;
        ffe_shift       = '0;
        thresh          = '0;
        align_pos       = '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        for (int p = 0; p < phases; p++) begin
            configure(p);
            for (int b = 0; b < blocks; b++) begin
                set_align(b);
                repeat (words_per_block) send_word();
                repeat (drain_cycles) drive_bubble();
            end
        end

        if (exp_codes_q.size() != 0 || words_seen != words_sent) begin
            other_errors++;
            $display("Sent %0d words but only %0d came out", words_sent, words_seen);
        end
        $display("Words sent %0d, checked %0d; errors valid %0d, data %0d, other %0d",
                 words_sent, words_seen, valid_errors, data_errors, other_errors);
        if (valid_errors + data_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_eq_model_pkg.sv ====
`default_nettype none

package tb_eq_model_pkg;

    typedef lane_pkg::code_t [lane_pkg::lanes-1:0]                    code_word_t;
    typedef eq_pkg::est_t    [lane_pkg::lanes-1:0]                    est_word_t;
    typedef eq_pkg::weight_t [eq_pkg::taps-1:0][lane_pkg::lanes-1:0]  weight_set_t;
    typedef logic            [eq_pkg::taps-1:0][lane_pkg::lanes-1:0]  disable_set_t;
    typedef eq_pkg::shift_t  [lane_pkg::lanes-1:0]                    shift_set_t;
    typedef eq_pkg::thresh_t [lane_pkg::lanes-1:0]                    thresh_set_t;
    typedef logic            [lane_pkg::lanes-1:0]                    bit_word_t;

    // FIR over the current word, reaching back into the previous word
    function automatic est_word_t ffe_word(input code_word_t cur, input code_word_t prev,
                                           input weight_set_t w, input disable_set_t dis,
                                           input shift_set_t sh);
        est_word_t est;
        int        sum;
        int        sample;
        int        hi;
        int        lo;
        hi = (2 ** (eq_pkg::est_w - 1)) - 1;
        lo = -(2 ** (eq_pkg::est_w - 1));
        for (int i = 0; i < lane_pkg::lanes; i++) begin
            sum = 0;
            for (int k = 0; k < eq_pkg::taps; k++) begin
                if (i - k >= 0) begin
                    sample = int'($signed(cur[i-k]));
                end else begin
                    sample = int'($signed(prev[lane_pkg::lanes+i-k]));
                end
                if (!dis[k][i]) begin
                    sum = sum + int'($signed(w[k][i])) * sample;
                end
            end
            sum = sum >>> sh[i];
            if (sum > hi) begin
                sum = hi;
            end else if (sum < lo) begin
                sum = lo;
            end
            est[i] = eq_pkg::est_t'(sum);
        end
        return est;
    endfunction

    function automatic bit_word_t slice_word(input est_word_t est, input thresh_set_t th);
        bit_word_t bits;
        for (int i = 0; i < lane_pkg::lanes; i++) begin
            bits[i] = int'($signed(est[i])) > int'($signed(th[i]));
        end
        return bits;
    endfunction

    // Positions 0..7 hold the previous word, 8..15 the current one
    function automatic bit_word_t align_word(input bit_word_t prev, input bit_word_t cur,
                                             input lane_pkg::align_t pos);
        logic [2*lane_pkg::lanes-1:0] seq;
        bit_word_t                    out;
        for (int p = 0; p < lane_pkg::lanes; p++) begin
            seq[p]                 = prev[p];
            seq[p+lane_pkg::lanes] = cur[p];
        end
        for (int i = 0; i < lane_pkg::lanes; i++) begin
            out[i] = seq[i+int'(pos)];
        end
        return out;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/bits_estimator_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bits_estimator_top (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    in_valid,
    input  lane_pkg::code_t [lane_pkg::lanes-1:0]                   in_codes,
    input  eq_pkg::weight_t [eq_pkg::taps-1:0][lane_pkg::lanes-1:0] weights,
    input  logic            [eq_pkg::taps-1:0][lane_pkg::lanes-1:0] disable_product,
    input  eq_pkg::shift_t  [lane_pkg::lanes-1:0]                   ffe_shift,
    input  eq_pkg::thresh_t [lane_pkg::lanes-1:0]                   thresh,
    input  lane_pkg::align_t                                        align_pos,
    output logic                                                    out_valid,
    output lane_pkg::code_t [lane_pkg::lanes-1:0]                   out_codes,
    output eq_pkg::est_t    [lane_pkg::lanes-1:0]                   out_est,
    output lane_pkg::lane_bits_t                                    out_bits
);

    stage_if hist_s ();
    stage_if ffe_s ();
    stage_if slice_s ();

    lane_pkg::code_t [lane_pkg::lanes-1:0] prev_codes;

    code_history u_code_history (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_codes   (in_codes),
        .out        (hist_s.src),
        .prev_codes (prev_codes)
    );

    ffe_stage u_ffe_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .in              (hist_s.dst),
        .prev_codes      (prev_codes),
        .weights         (weights),
        .disable_product (disable_product),
        .ffe_shift       (ffe_shift),
        .out             (ffe_s.src)
    );

    slicer_stage u_slicer_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .in     (ffe_s.dst),
        .thresh (thresh),
        .out    (slice_s.src)
    );

    // Last stage drives the outputs straight from its registers
    bit_aligner u_bit_aligner (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (slice_s.dst),
        .align_pos (align_pos),
        .out_valid (out_valid),
        .out_codes (out_codes),
        .out_est   (out_est),
        .out_bits  (out_bits)
    );

endmodule

`default_nettype wire

// ==== verilog/bit_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_aligner (
    input  logic                                  clk,
    input  logic                                  rst_n,
    stage_if.dst                                  in,
    input  lane_pkg::align_t                      align_pos,
    output logic                                  out_valid,
    output lane_pkg::code_t [lane_pkg::lanes-1:0] out_codes,
    output eq_pkg::est_t    [lane_pkg::lanes-1:0] out_est,
    output lane_pkg::lane_bits_t                  out_bits
);

    // Last valid slicer word
    lane_pkg::lane_bits_t prev_bits;

    // Previous word in positions 0 to 7, current word above it
    logic [2*lane_pkg::lanes-1:0] bit_seq;

    assign bit_seq = {in.bits, prev_bits};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_codes <= '0;
            out_est   <= '0;
            out_bits  <= '0;
            prev_bits <= '0;
        end else begin
            out_valid <= in.valid;
            if (in.valid) begin
                out_codes <= in.codes;
                out_est   <= in.est;
                out_bits  <= bit_seq[align_pos +: lane_pkg::lanes];
                prev_bits <= in.bits;
            end
        end
    end

    property p_valid_known;
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid);
    endproperty

    a_valid_known: assert property (p_valid_known)
        else $error("bit_aligner: out_valid unknown %h", out_valid);

endmodule

`default_nettype wire

// ==== verilog/slicer_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module slicer_stage (
    input  logic                                    clk,
    input  logic                                    rst_n,
    stage_if.dst                                    in,
    input  eq_pkg::thresh_t [lane_pkg::lanes-1:0]   thresh,
    stage_if.src                                    out
);

    lane_pkg::lane_bits_t bits_next;

    always_comb begin
        for (int i = 0; i < lane_pkg::lanes; i++) begin
            bits_next[i] = $signed(in.est[i]) > $signed(thresh[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
            out.codes <= '0;
            out.est   <= '0;
            out.bits  <= '0;
        end else begin
            out.valid <= in.valid;
            if (in.valid) begin
                out.codes <= in.codes;
                out.est   <= in.est;
                out.bits  <= bits_next;
            end
        end
    end

    // Each registered decision matches the estimate it was made from
    for (genvar i = 0; i < lane_pkg::lanes; i++) begin : g_check
        a_decision: assert property (
            @(posedge clk) disable iff (!rst_n)
            $past(rst_n) && $past(in.valid) |->
                out.bits[i] == ($signed($past(in.est[i])) > $signed($past(thresh[i]))))
            else $error("slicer_stage: lane %0d bit %h est %h", i, out.bits[i],
                        $past(in.est[i]));
    end

endmodule

`default_nettype wire

// ==== verilog/ffe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ffe_stage (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    stage_if.dst                                                        in,
    input  lane_pkg::code_t [lane_pkg::lanes-1:0]                       prev_codes,
    input  eq_pkg::weight_t [eq_pkg::taps-1:0][lane_pkg::lanes-1:0]     weights,
    input  logic            [eq_pkg::taps-1:0][lane_pkg::lanes-1:0]     disable_product,
    input  eq_pkg::shift_t  [lane_pkg::lanes-1:0]                       ffe_shift,
    stage_if.src                                                        out
);

    // Previous word in the low lanes, current word in the high lanes
    lane_pkg::code_t [2*lane_pkg::lanes-1:0] window;
    eq_pkg::est_t    [lane_pkg::lanes-1:0]   est_next;

    assign window = {in.codes, prev_codes};

    always_comb begin
        eq_pkg::acc_t    sum;
        eq_pkg::acc_t    shifted;
        eq_pkg::weight_t w;
        lane_pkg::code_t c;

        for (int i = 0; i < lane_pkg::lanes; i++) begin
            sum = '0;
            for (int k = 0; k < eq_pkg::taps; k++) begin
                // Tap k looks k samples back and may reach into the previous word
                w = weights[k][i];
                c = window[lane_pkg::lanes + i - k];
                if (!disable_product[k][i]) begin
                    sum = sum + eq_pkg::acc_t'(w) * eq_pkg::acc_t'(c);
                end
            end

            shifted = sum >>> ffe_shift[i];

            if (shifted > eq_pkg::est_max) begin
                est_next[i] = eq_pkg::est_t'(eq_pkg::est_max);
            end else if (shifted < eq_pkg::est_min) begin
                est_next[i] = eq_pkg::est_t'(eq_pkg::est_min);
            end else begin
                est_next[i] = eq_pkg::est_t'(shifted);
            end
        end
    end

    // Decisions are made by the slicer
    assign out.bits = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
            out.codes <= '0;
            out.est   <= '0;
        end else begin
            out.valid <= in.valid;
            if (in.valid) begin
                out.codes <= in.codes;
                out.est   <= est_next;
            end
        end
    end

    // Valid moves through the stage in exactly one clock
    property p_valid_delay;
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> out.valid == $past(in.valid);
    endproperty

    a_valid_delay: assert property (p_valid_delay)
        else $error("ffe_stage: out.valid %h after in.valid %h",
                    out.valid, $past(in.valid));

endmodule

`default_nettype wire

// ==== verilog/code_history.sv ====
`timescale 1ns/1ps
`default_nettype none

module code_history (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  lane_pkg::code_t [lane_pkg::lanes-1:0] in_codes,
    stage_if.src                                 out,
    output lane_pkg::code_t [lane_pkg::lanes-1:0] prev_codes
);

    // Codes of the last valid output word
    lane_pkg::code_t [lane_pkg::lanes-1:0] last_codes;

    // Estimates and decisions are filled further down
    assign out.est  = '0;
    assign out.bits = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid  <= 1'b0;
            out.codes  <= '0;
            prev_codes <= '0;
        end else begin
            out.valid <= in_valid;
            // Bubbles leave the history untouched
            if (in_valid) begin
                out.codes  <= in_codes;
                prev_codes <= out.codes;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_codes <= '0;
        end else if (out.valid) begin
            last_codes <= out.codes;
        end
    end

    // A valid word sees the last valid word as its history across any bubbles
    property p_history_follows;
        @(posedge clk) disable iff (!rst_n)
        out.valid |-> prev_codes == last_codes;
    endproperty

    a_history_follows: assert property (p_history_follows)
        else $error("code_history: prev_codes %h does not match last word %h",
                    prev_codes, last_codes);

endmodule

`default_nettype wire

// ==== verilog/stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One word moving between two pipeline stages
interface stage_if;

    logic                                    valid;
    lane_pkg::code_t  [lane_pkg::lanes-1:0]  codes;
    eq_pkg::est_t     [lane_pkg::lanes-1:0]  est;
    lane_pkg::lane_bits_t                    bits;

    modport src (
        output valid,
        output codes,
        output est,
        output bits
    );

    modport dst (
        input valid,
        input codes,
        input est,
        input bits
    );

endinterface

`default_nettype wire

// ==== verilog/eq_pkg.sv ====
`default_nettype none

package eq_pkg;

    // FFE shape
    localparam int taps     = 4;
    localparam int weight_w = 8;
    localparam int shift_w  = 3;

    // Estimate and accumulator widths
    localparam int est_w = 10;
    localparam int acc_w = 18;

    // Saturation limits of an estimate
    localparam int est_max = (1 << (est_w - 1)) - 1;
    localparam int est_min = -(1 << (est_w - 1));

    // Clocks from input word to output word
    localparam int latency = 4;

    typedef logic signed [weight_w-1:0] weight_t;
    typedef logic        [shift_w-1:0]  shift_t;
    typedef logic signed [est_w-1:0]    est_t;
    typedef logic signed [est_w-1:0]    thresh_t;
    typedef logic signed [acc_w-1:0]    acc_t;

endpackage

`default_nettype wire

// ==== verilog/lane_pkg.sv ====
`default_nettype none

package lane_pkg;

    // Parallel word format from the ADC
    localparam int lanes  = 8;
    localparam int code_w = 8;

    // One signed ADC code
    typedef logic signed [code_w-1:0] code_t;

    // One slicer decision per lane with lane 0 as the earliest sample
    typedef logic [lanes-1:0] lane_bits_t;

    // Offset of the output window in the two-word bit sequence
    typedef logic [$clog2(lanes)-1:0] align_t;

endpackage

`default_nettype wire
